// File: src/memBusPkg.sv
`default_nettype none

package memBusPkg;

    // RAM side of the subsystem, one byte per cycle
    localparam int addrWidth = 32;
    localparam int byteWidth = 8;

    // request toward the synchronous RAM
    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic [byteWidth-1:0] wdata;
        logic                 write;
    } ramReq;

    // who currently owns the RAM port
    typedef enum logic [1:0] {
        stIdle,
        stFetch,
        stLoad,
        stStore
    } arbState;

endpackage

`default_nettype wire

// File: src/cpuReqPkg.sv
`default_nettype none

package cpuReqPkg;

    localparam int xlen = 32;

    // instruction queue in front of the core
    localparam int fetchDepth = 4;
    localparam int fetchPtrWidth = $clog2(fetchDepth);

    // access length in bytes
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen;

    typedef enum logic {
        lsLoad,
        lsStore
    } lsKind;

    // one data access from the core
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        lsKind           kind;
        accessLen        len;
        logic            signedLoad;
    } dataReq;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetchedInst;

endpackage

`default_nettype wire

// File: src/memArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module memArbiter (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              rdy,
    input  wire                              ioBufferFull,
    input  wire  [memBusPkg::byteWidth-1:0]  ramData,
    input  wire                              fetchEn,
    input  wire  [cpuReqPkg::xlen-1:0]       fetchAddr,
    input  wire                              dataEn,
    input  wire  cpuReqPkg::dataReq          dataIn,
    output memBusPkg::ramReq                 ramOut,
    output logic                             fetchDone,
    output logic [cpuReqPkg::xlen-1:0]       fetchWord,
    output logic                             dataDoneRaw,
    output logic [cpuReqPkg::xlen-1:0]       dataWord,
    output logic                             fetchBusy,
    output logic                             dataBusy
);
    import memBusPkg::*;
    import cpuReqPkg::*;

    arbState state;

    logic [addrWidth-1:0] baseAddr;
    accessLen             lenReg;
    logic [xlen-1:0]      wdataReg;
    logic [xlen-1:0]      asmReg;

    // bytes issued to the RAM and bytes already captured
    logic [2:0] issCnt;
    logic [2:0] capCnt;
    // a read address went out last cycle
    logic       pend;

    logic            active;
    logic            readState;
    logic            grantData;
    logic            grantFetch;
    logic            issue;
    logic [2:0]      capTotal;
    logic            readDone;
    logic            storeLast;
    logic [xlen-1:0] word;

    assign active    = rdy && !ioBufferFull;
    assign readState = (state == stFetch) || (state == stLoad);

    // data accesses win over fetches
    assign grantData  = active && (state == stIdle) && dataEn;
    assign grantFetch = active && (state == stIdle) && !dataEn && fetchEn;

    assign issue     = active && readState && (issCnt < lenReg);
    assign capTotal  = capCnt + {2'b00, pend};
    assign readDone  = active && readState && (capTotal == lenReg);
    assign storeLast = active && (state == stStore) && (issCnt == lenReg - 3'd1);

    // returning byte goes straight into its lane
    always_comb begin
        word = asmReg;
        if (pend) begin
            word[capCnt[1:0]*8 +: 8] = ramData;
        end
    end

    always_comb begin
        ramOut.addr  = baseAddr + {{(addrWidth-3){1'b0}}, issCnt};
        ramOut.wdata = wdataReg[issCnt[1:0]*8 +: 8];
        ramOut.write = active && (state == stStore);
    end

    assign fetchDone   = readDone && (state == stFetch);
    assign fetchWord   = word;
    assign dataDoneRaw = (readDone && (state == stLoad)) || storeLast;
    assign dataWord    = word;

    // ownership includes the grant cycle itself
    assign fetchBusy = (state == stFetch) || grantFetch;
    assign dataBusy  = (state == stLoad) || (state == stStore) || grantData;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= stIdle;
            issCnt <= '0;
            capCnt <= '0;
            pend   <= 1'b0;
        end else begin
            pend <= issue;
            // capture still runs in a halted cycle
            if (pend) begin
                capCnt <= capTotal;
            end
            if (active) begin
                case (state)
                    stIdle: begin
                        if (grantData) begin
                            state <= (dataIn.kind == lsStore) ? stStore : stLoad;
                        end else if (grantFetch) begin
                            state <= stFetch;
                        end
                    end
                    stFetch, stLoad: begin
                        if (issue) begin
                            issCnt <= issCnt + 3'd1;
                        end
                        if (readDone) begin
                            state  <= stIdle;
                            issCnt <= '0;
                            capCnt <= '0;
                        end
                    end
                    stStore: begin
                        issCnt <= issCnt + 3'd1;
                        if (storeLast) begin
                            state  <= stIdle;
                            issCnt <= '0;
                        end
                    end
                    default: begin
                        state <= stIdle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grantData) begin
            baseAddr <= dataIn.addr;
            lenReg   <= dataIn.len;
            wdataReg <= dataIn.wdata;
        end else if (grantFetch) begin
            baseAddr <= fetchAddr;
            lenReg   <= lenWord;
        end
        if (pend) begin
            asmReg[capCnt[1:0]*8 +: 8] <= ramData;
        end
    end

endmodule

`default_nettype wire

// File: src/fetchBuffer.sv
`timescale 1ns/1ns
`default_nettype none

module fetchBuffer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        rdy,
    input  wire                        fetchDone,
    input  wire  [cpuReqPkg::xlen-1:0] fetchWord,
    input  wire                        fetchBusy,
    input  wire                        instTake,
    input  wire                        redirect,
    input  wire  [cpuReqPkg::xlen-1:0] redirectPc,
    output logic                       fetchEn,
    output logic [cpuReqPkg::xlen-1:0] fetchAddr,
    output logic                       instValid,
    output cpuReqPkg::fetchedInst      instOut
);
    import cpuReqPkg::*;

    localparam logic [xlen-1:0] resetPc = '0;

    fetchedInst queue [fetchDepth];

    logic [xlen-1:0]          pc;
    logic [fetchPtrWidth-1:0] wrPtr;
    logic [fetchPtrWidth-1:0] rdPtr;
    logic [fetchPtrWidth:0]   count;
    logic [fetchPtrWidth:0]   countNext;
    // drop the fetch that was in flight at a redirect
    logic                     discard;

    logic push;
    logic pop;

    assign push = fetchDone && !discard && !redirect;
    assign pop  = instTake && instValid;

    always_comb begin
        countNext = count;
        if (push && !pop) begin
            countNext = count + 1'b1;
        end else if (pop && !push) begin
            countNext = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= resetPc;
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            discard <= 1'b0;
            fetchEn <= 1'b0;
        end else if (rdy) begin
            if (redirect) begin
                pc      <= redirectPc;
                wrPtr   <= '0;
                rdPtr   <= '0;
                count   <= '0;
                discard <= fetchBusy && !fetchDone;
                fetchEn <= 1'b1;
            end else begin
                if (fetchDone && discard) begin
                    discard <= 1'b0;
                end
                if (push) begin
                    wrPtr <= wrPtr + 1'b1;
                    pc    <= pc + 32'd4;
                end
                if (pop) begin
                    rdPtr <= rdPtr + 1'b1;
                end
                count   <= countNext;
                fetchEn <= countNext != (fetchPtrWidth+1)'(fetchDepth);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && push) begin
            queue[wrPtr] <= '{pc: pc, inst: fetchWord};
        end
    end

    assign fetchAddr = pc;
    assign instValid = count != '0;
    assign instOut   = queue[rdPtr];

endmodule

`default_nettype wire

// File: src/loadStoreFront.sv
`timescale 1ns/1ns
`default_nettype none

module loadStoreFront (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        rdy,
    input  wire                        dataStart,
    input  wire  cpuReqPkg::dataReq    dataReqIn,
    input  wire                        dataDoneRaw,
    input  wire  [cpuReqPkg::xlen-1:0] dataWord,
    output logic                       dataEn,
    output cpuReqPkg::dataReq          dataOut,
    output logic                       dataBusy,
    output logic                       dataDone,
    output logic [cpuReqPkg::xlen-1:0] loadData
);
    import cpuReqPkg::*;

    dataReq reqReg;

    // keep only the low len bytes of the little-endian word
    function automatic logic [xlen-1:0] extend(input logic [xlen-1:0] raw,
                                               input accessLen len,
                                               input logic sgn);
        logic [xlen-1:0] res;
        case (len)
            lenByte: res = {{24{sgn & raw[7]}}, raw[7:0]};
            lenHalf: res = {{16{sgn & raw[15]}}, raw[15:0]};
            default: res = raw;
        endcase
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            dataEn   <= 1'b0;
            dataBusy <= 1'b0;
            dataDone <= 1'b0;
        end else if (rdy) begin
            dataDone <= 1'b0;
            if (dataStart && !dataBusy) begin
                dataEn   <= 1'b1;
                dataBusy <= 1'b1;
            end else if (dataDoneRaw) begin
                dataEn   <= 1'b0;
                dataBusy <= 1'b0;
                dataDone <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (dataStart && !dataBusy) begin
                reqReg <= dataReqIn;
            end
            if (dataDoneRaw && reqReg.kind == lsLoad) begin
                loadData <= extend(dataWord, reqReg.len, reqReg.signedLoad);
            end
        end
    end

    assign dataOut = reqReg;

endmodule

`default_nettype wire

// File: src/memSubsystem.sv
`timescale 1ns/1ns
`default_nettype none

module memSubsystem (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              rdy,
    input  wire                              ioBufferFull,
    input  wire                              dataStart,
    input  wire  cpuReqPkg::dataReq          dataReqIn,
    output logic                             dataBusy,
    output logic                             dataDone,
    output logic [cpuReqPkg::xlen-1:0]       loadData,
    output logic                             instValid,
    output cpuReqPkg::fetchedInst            instOut,
    input  wire                              instTake,
    input  wire                              redirect,
    input  wire  [cpuReqPkg::xlen-1:0]       redirectPc,
    output memBusPkg::ramReq                 ramOut,
    input  wire  [memBusPkg::byteWidth-1:0]  ramData
);
    import cpuReqPkg::*;

    logic            fetchEn;
    logic [xlen-1:0] fetchAddr;
    logic            fetchDone;
    logic [xlen-1:0] fetchWord;
    logic            fetchBusy;
    logic            dataEn;
    dataReq          dataHeld;
    logic            dataDoneRaw;
    logic [xlen-1:0] dataWord;

    memArbiter arb0 (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .ramData      (ramData),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .dataEn       (dataEn),
        .dataIn       (dataHeld),
        .ramOut       (ramOut),
        .fetchDone    (fetchDone),
        .fetchWord    (fetchWord),
        .dataDoneRaw  (dataDoneRaw),
        .dataWord     (dataWord),
        .fetchBusy    (fetchBusy),
        .dataBusy     ()
    );

    fetchBuffer fetch0 (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .fetchDone  (fetchDone),
        .fetchWord  (fetchWord),
        .fetchBusy  (fetchBusy),
        .instTake   (instTake),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .instValid  (instValid),
        .instOut    (instOut)
    );

    loadStoreFront lsf0 (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .dataStart   (dataStart),
        .dataReqIn   (dataReqIn),
        .dataDoneRaw (dataDoneRaw),
        .dataWord    (dataWord),
        .dataEn      (dataEn),
        .dataOut     (dataHeld),
        .dataBusy    (dataBusy),
        .dataDone    (dataDone),
        .loadData    (loadData)
    );

endmodule

`default_nettype wire

// File: tests/memChecker.sv
`timescale 1ns/1ns
`default_nettype none

module memChecker (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         rdy,
    input  wire                         ioBufferFull,
    input  wire                         dataStart,
    input  wire  cpuReqPkg::dataReq     dataReqIn,
    input  wire                         dataBusy,
    input  wire                         dataDone,
    input  wire  [cpuReqPkg::xlen-1:0]  loadData,
    input  wire                         instValid,
    input  wire  cpuReqPkg::fetchedInst instOut,
    input  wire                         instTake,
    input  wire                         redirect,
    input  wire  [cpuReqPkg::xlen-1:0]  redirectPc,
    input  wire  memBusPkg::ramReq      ramOut,
    output int                          errCount
);
    import cpuReqPkg::*;

    logic [7:0]      shadow [65536];
    dataReq          curReq;
    logic            pending = 1'b0;
    int              wrIdx = 0;
    logic [xlen-1:0] expPc = '0;
    logic            quiet = 1'b1;

    initial errCount = 0;

    function automatic logic [xlen-1:0] expectInst(input logic [xlen-1:0] pc);
        return {shadow[16'(pc + 3)], shadow[16'(pc + 2)], shadow[16'(pc + 1)], shadow[pc[15:0]]};
    endfunction

    // little-endian bytes, then sign or zero fill above len
    function automatic logic [xlen-1:0] expectLoad(input logic [xlen-1:0] addr, input int len,
                                                   input logic signedLoad);
        logic [xlen-1:0] val;
        logic            fill;
        int              i;
        val = '0;
        for (i = 0; i < len; i++) begin
            val[8*i +: 8] = shadow[16'(addr + 32'(i))];
        end
        fill = signedLoad && val[8*len-1];
        for (i = len; i < 4; i++) begin
            val[8*i +: 8] = {8{fill}};
        end
        return val;
    endfunction

    task automatic compare(input string name, input logic [xlen-1:0] got,
                           input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
            errCount++;
        end
    endtask

    task automatic fault(input string msg);
        $display("check failed at %0t: %s", $time, msg);
        errCount++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pending = 1'b0;
            expPc   = '0;
            quiet   = 1'b1;
        end else begin
            if (quiet && (dataBusy || dataDone || ramOut.write)) begin
                fault("data side active before the first instruction arrived");
            end
            if (instValid) begin
                quiet = 1'b0;
            end
            if (dataBusy && !pending) begin
                fault("dataBusy high with no access in progress");
            end else if (pending && !dataBusy && !dataDone) begin
                fault("dataBusy dropped before dataDone");
            end
            if (ramOut.write && (!rdy || ioBufferFull)) begin
                fault("RAM write issued during a halt");
            end else if (ramOut.write && (!pending || curReq.kind != lsStore)) begin
                fault("RAM write with no store in progress");
            end else if (ramOut.write) begin
                // store bytes go out in order from the request address
                compare("ramOut.addr", ramOut.addr, curReq.addr + 32'(wrIdx));
                compare("ramOut.wdata", 32'(ramOut.wdata), 32'(curReq.wdata[8*wrIdx +: 8]));
                wrIdx++;
            end
            if (rdy && redirect) begin
                expPc = redirectPc;
            end else if (rdy && instTake && instValid) begin
                compare("instOut.pc", instOut.pc, expPc);
                compare("instOut.inst", instOut.inst, expectInst(expPc));
                expPc = expPc + 32'd4;
            end
            if (rdy && dataDone && !pending) begin
                fault("dataDone with no access in progress");
            end else if (rdy && dataDone && curReq.kind == lsLoad) begin
                compare("loadData", loadData,
                        expectLoad(curReq.addr, int'(curReq.len), curReq.signedLoad));
                pending = 1'b0;
            end else if (rdy && dataDone) begin
                if (wrIdx != int'(curReq.len)) begin
                    fault("store wrote the wrong number of bytes");
                end
                for (int i = 0; i < int'(curReq.len); i++) begin
                    shadow[16'(curReq.addr + 32'(i))] = curReq.wdata[8*i +: 8];
                end
                pending = 1'b0;
            end
            if (rdy && dataStart && !dataBusy) begin
                curReq  = dataReqIn;
                pending = 1'b1;
                wrIdx   = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/memSubsystemTb.sv
`timescale 1ns/1ns
`default_nettype none

module memSubsystemTb;
    import cpuReqPkg::*;

    localparam int instCount      = 64;
    localparam int pairCount      = 24;
    // one access behind a fetch, stretched by halts
    localparam int accessCycles   = 40;
    localparam int testAccesses   = 2 * instCount + 4 * pairCount + 40;
    localparam int watchdogCycles = 2 * testAccesses * accessCycles;
    localparam int waitLimit      = 4 * accessCycles;

    logic             clk = 1'b0;
    logic             rst = 1'b1;
    logic             rdy = 1'b1;
    logic             ioBufferFull = 1'b0;
    logic             dataStart = 1'b0;
    dataReq           dataReqIn = '0;
    logic             dataBusy;
    logic             dataDone;
    logic [xlen-1:0]  loadData;
    logic             instValid;
    fetchedInst       instOut;
    logic             instTake = 1'b0;
    logic             redirect = 1'b0;
    logic [xlen-1:0]  redirectPc = '0;
    memBusPkg::ramReq ramOut;
    logic [7:0]       ramData = '0;

    logic [7:0] ram [65536];
    integer     seed = 1;
    integer     haltSeed = 1;
    logic       haltOn = 1'b0;
    int         chkErrors;
    int         tbErrors = 0;
    int         errBase = 0;
    int         testsFailed = 0;

    memSubsystem dut0 (.*);
    memChecker chk0 (.*, .errCount(chkErrors));

    always #2 clk = ~clk;

    // byte RAM, read data one cycle after the address
    always @(posedge clk) begin
        if (ramOut.write) begin
            ram[ramOut.addr[15:0]] <= ramOut.wdata;
        end
        ramData <= ram[ramOut.addr[15:0]];
    end

    always @(posedge clk) begin
        #1;
        rdy          = !haltOn || ({$random(haltSeed)} % 4 != 0);
        ioBufferFull = haltOn && ({$random(haltSeed)} % 6 == 0);
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", watchdogCycles);
        $display(">>> FAIL");
        $finish;
    end

    function automatic accessLen randomLen();
        int pick;
        pick = {$random(seed)} % 3;
        return (pick == 0) ? lenByte : (pick == 1) ? lenHalf : lenWord;
    endfunction

    task automatic finishTest(input int num, input string name);
        int errs;
        errs = chkErrors + tbErrors - errBase;
        errBase = chkErrors + tbErrors;
        if (errs != 0) begin
            testsFailed++;
        end
        $display("test %0d %s: %0d errors", num, name, errs);
    endtask

    task automatic runAccess(input dataReq req);
        int n;
        n = 0;
        dataReqIn = req;
        dataStart = 1'b1;
        do begin
            @(posedge clk);
            n++;
        end while (!(rdy && !dataBusy) && n < waitLimit);
        #1;
        dataStart = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(rdy && dataDone) && n < waitLimit);
        if (!(rdy && dataDone)) begin
            $display("no dataDone within %0d cycles for address %h", waitLimit, req.addr);
            tbErrors++;
        end
        #1;
    endtask

    task automatic takeInsts(input int n);
        int got;
        int cycles;
        got = 0;
        cycles = 0;
        instTake = 1'b1;
        while (got < n && cycles < n * waitLimit) begin
            @(posedge clk);
            cycles++;
            if (rdy && instValid) begin
                got++;
            end
        end
        if (got < n) begin
            $display("only %0d of %0d instructions delivered", got, n);
            tbErrors++;
        end
        #1;
        instTake = 1'b0;
    endtask

    task automatic redirectTo(input logic [xlen-1:0] target);
        redirectPc = target;
        redirect = 1'b1;
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    task automatic storeThenLoad();
        logic [xlen-1:0] addrs [pairCount];
        dataReq          req;
        int              i;
        for (i = 0; i < pairCount; i++) begin
            addrs[i] = 32'h8000 + ({$random(seed)} % 240);
            req = '{addr: addrs[i], wdata: $random(seed), kind: lsStore,
                    len: randomLen(), signedLoad: 1'b0};
            runAccess(req);
        end
        for (i = 0; i < pairCount; i++) begin
            req = '{addr: addrs[i], wdata: '0, kind: lsLoad,
                    len: randomLen(), signedLoad: 1'($random(seed))};
            runAccess(req);
        end
    endtask

    initial begin
        dataReq req;
        int     i;
        for (i = 0; i < 65536; i++) begin
            ram[i] = 8'($random(seed));
            chk0.shadow[i] = ram[i];
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        i = 0;
        do begin
            @(posedge clk);
            i++;
        end while (!instValid && i < waitLimit);
        #1;
        if (!instValid) begin
            $display("no instruction became valid after reset");
            tbErrors++;
        end
        finishTest(1, "reset state");

        takeInsts(instCount);
        finishTest(2, "sequential fetch");

        storeThenLoad();
        finishTest(3, "stores then loads");

        // keep the queue draining so a fetch competes for the port
        instTake = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        req = '{addr: 32'h9000 + ({$random(seed)} % 240), wdata: $random(seed),
                kind: lsStore, len: lenWord, signedLoad: 1'b0};
        runAccess(req);
        req.kind = lsLoad;
        runAccess(req);
        instTake = 1'b0;
        finishTest(4, "data access during fetch");

        repeat (30) @(posedge clk);
        #1;
        for (i = 0; i < 2; i++) begin
            redirectTo(32'h1000 + (({$random(seed)} % 32'h0c00) << 2));
            takeInsts(8);
        end
        finishTest(5, "redirect");

        haltOn = 1'b1;
        takeInsts(instCount);
        storeThenLoad();
        haltOn = 1'b0;
        finishTest(6, "halts");

        $display("tests run 6, tests with errors %0d, total errors %0d",
                 testsFailed, chkErrors + tbErrors);
        if (testsFailed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
src/memBusPkg.sv
src/cpuReqPkg.sv
src/memArbiter.sv
src/fetchBuffer.sv
src/loadStoreFront.sv
src/memSubsystem.sv
tests/memChecker.sv
tests/memSubsystemTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= vlog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ns

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@! grep -q ">>> FAIL" $(LOG)
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
